/* mac_addr_reg.sv */
`timescale 1ns/1ns

module mac_addr_reg
  import mac_cfg_pkg::*;
(
  input  logic              mclk,
  input  logic              rst_n,
  input  logic [ADDR_W-1:0] ica,
  input  logic              eccrhin,
  output logic [ADDR_W-1:0] lca,
  output logic [ADDR_W-1:0] nlca,
  output logic [MCA_W-1:0]  mca,
  output logic              eccr
);

  // Current microaddress and ECCR flop
  always_ff @(posedge mclk) begin
    if (!rst_n) begin
      lca  <= RESET_ADDR;
      eccr <= 1'b0;
    end else begin
      lca  <= ica;
      eccr <= eccrhin;
    end
  end

  // Incrementer wraps from FFFF to 0
  assign nlca = lca + 1'b1;

  // Control-store address
  assign mca = lca[MCA_W-1:0];

endmodule

/* mac_addr_select.sv */
`timescale 1ns/1ns

module mac_addr_select
  import mac_cfg_pkg::*;
  import mac_types_pkg::*;
(
  input  mac_sel_t          sel,
  input  logic [ADDR_W-1:0] lca,
  input  logic [ADDR_W-1:0] pr,
  input  logic [ADDR_W-1:0] add,
  input  logic [ADDR_W-1:0] cd,
  input  logic [ADDR_W-1:0] nlca,
  output logic [ADDR_W-1:0] ica
);

  logic [ADDR_W-1:0] term_hold;
  logic [ADDR_W-1:0] term_pr;
  logic [ADDR_W-1:0] term_add;
  logic [ADDR_W-1:0] term_cd;
  logic [ADDR_W-1:0] term_nlca;
  logic [ADDR_W-1:0] term_trap;

  // Each source gated by its own strobe
  assign term_hold = {ADDR_W{sel.hold}} & lca;
  assign term_pr   = {ADDR_W{sel.psel}} & pr;
  assign term_add  = {ADDR_W{sel.addsel}} & add;
  assign term_cd   = {ADDR_W{sel.cdsel}} & cd;
  assign term_nlca = {ADDR_W{sel.nlcasel}} & nlca;
  assign term_trap = {ADDR_W{sel.trap}} & TRAP_ADDR;

  // Wired OR of all gated terms
  // At most one strobe is active in a cycle
  assign ica = term_hold | term_pr | term_add | term_cd | term_nlca | term_trap;

endmodule

/* mac_cfg_pkg.sv */
package mac_cfg_pkg;

  // Microaddress and control-store widths
  localparam int ADDR_W = 16;
  localparam int MCA_W  = 10;

  // Counted microloops
  localparam int CNT_W = 8;

  // Microsubroutine nesting
  localparam int STACK_DEPTH = 4;
  localparam int STACK_PTR_W = $clog2(STACK_DEPTH + 1);
  localparam int STACK_IDX_W = $clog2(STACK_DEPTH);

  // Fixed microaddresses
  localparam logic [ADDR_W-1:0] TRAP_ADDR  = 16'h03F0;
  localparam logic [ADDR_W-1:0] RESET_ADDR = '0;

endpackage

/* mac_loop_counter.sv */
`timescale 1ns/1ns

module mac_loop_counter
  import mac_cfg_pkg::*;
(
  input  logic             mclk,
  input  logic             rst_n,
  input  logic             load,
  input  logic             dec,
  input  logic [CNT_W-1:0] load_value,
  output logic             zero
);

  logic [CNT_W-1:0] count;

  // Load wins over decrement
  always_ff @(posedge mclk) begin
    if (!rst_n) begin
      count <= '0;
    end else if (load) begin
      count <= load_value;
    end else if (dec) begin
      count <= count - 1'b1;
    end
  end

  assign zero = (count == '0);

endmodule

/* mac_return_stack.sv */
`timescale 1ns/1ns

module mac_return_stack
  import mac_cfg_pkg::*;
(
  input  logic              mclk,
  input  logic              rst_n,
  input  logic              push,
  input  logic              pop,
  input  logic [ADDR_W-1:0] push_addr,
  output logic [ADDR_W-1:0] top,
  output logic              empty,
  output logic              full
);

  logic [ADDR_W-1:0]      mem [STACK_DEPTH];
  logic [STACK_PTR_W-1:0] ptr;
  logic [STACK_IDX_W-1:0] top_idx;

  // Ptr counts entries in use and is one bit wider than the index
  always_ff @(posedge mclk) begin
    if (!rst_n) begin
      ptr <= '0;
    end else if (push) begin
      ptr <= ptr + 1'b1;
    end else if (pop) begin
      ptr <= ptr - 1'b1;
    end
  end

  always_ff @(posedge mclk) begin
    if (push) begin
      mem[ptr[STACK_IDX_W-1:0]] <= push_addr;
    end
  end

  assign top_idx = STACK_IDX_W'(ptr - 1'b1);
  assign empty   = (ptr == '0);
  assign full    = (ptr == STACK_PTR_W'(STACK_DEPTH));

  // Reads zero when nothing is stacked
  assign top = empty ? '0 : mem[top_idx];

endmodule

/* mac_seq_fsm.sv */
`timescale 1ns/1ns

module mac_seq_fsm
  import mac_types_pkg::*;
(
  input  logic     mclk,
  input  logic     rst_n,
  input  mac_op_t  op,
  input  logic     hold,
  input  logic     stack_empty,
  input  logic     stack_full,
  input  logic     cnt_zero,
  output mac_sel_t sel,
  output logic     push,
  output logic     pop,
  output logic     cnt_load,
  output logic     cnt_dec,
  output logic     fault
);

  typedef enum logic [1:0] {
    ST_RUN   = 2'd0,
    ST_HELD  = 2'd1,
    ST_FAULT = 2'd2
  } state_t;

  state_t state;
  state_t state_next;

  always_ff @(posedge mclk) begin
    if (!rst_n) begin
      state <= ST_RUN;
    end else begin
      state <= state_next;
    end
  end

  always_comb begin
    sel        = '0;
    push       = 1'b0;
    pop        = 1'b0;
    cnt_load   = 1'b0;
    cnt_dec    = 1'b0;
    state_next = state;
    case (state)
      ST_RUN, ST_HELD: begin
        if (hold) begin
          // Stall on the current address
          sel.hold   = 1'b1;
          state_next = ST_HELD;
        end else begin
          state_next = ST_RUN;
          case (op)
            OP_JUMP: sel.addsel = 1'b1;
            OP_DISP: sel.cdsel  = 1'b1;
            OP_CALL: begin
              if (stack_full) begin
                sel.trap   = 1'b1;
                state_next = ST_FAULT;
              end else begin
                sel.addsel = 1'b1;
                push       = 1'b1;
              end
            end
            OP_RET: begin
              if (stack_empty) begin
                sel.trap   = 1'b1;
                state_next = ST_FAULT;
              end else begin
                sel.psel = 1'b1;
                pop      = 1'b1;
              end
            end
            OP_LDCNT: begin
              sel.nlcasel = 1'b1;
              cnt_load    = 1'b1;
            end
            OP_LOOP: begin
              // Jump back while count remains, else fall through
              if (cnt_zero) begin
                sel.nlcasel = 1'b1;
              end else begin
                sel.addsel = 1'b1;
                cnt_dec    = 1'b1;
              end
            end
            default: sel.nlcasel = 1'b1;
          endcase
        end
      end
      // Parked at the trap address until reset
      default: sel.hold = 1'b1;
    endcase
  end

  assign fault = (state == ST_FAULT);

endmodule

/* mac_sequencer.sv */
`timescale 1ns/1ns

module mac_sequencer
  import mac_cfg_pkg::*;
  import mac_types_pkg::*;
(
  input  logic              mclk,
  input  logic              rst_n,
  input  mac_cmd_t          cmd,
  input  logic [ADDR_W-1:0] cd,
  input  logic              hold,
  input  logic              eccrhin,
  output logic [ADDR_W-1:0] lca,
  output logic [MCA_W-1:0]  mca,
  output logic              eccr,
  output logic              fault
);

  mac_sel_t          sel;
  logic              push;
  logic              pop;
  logic              cnt_load;
  logic              cnt_dec;
  logic              cnt_zero;
  logic              stack_empty;
  logic              stack_full;
  logic [ADDR_W-1:0] pr;
  logic [ADDR_W-1:0] nlca;
  logic [ADDR_W-1:0] ica;

  mac_seq_fsm fsm0 (
    .mclk        (mclk),
    .rst_n       (rst_n),
    .op          (cmd.op),
    .hold        (hold),
    .stack_empty (stack_empty),
    .stack_full  (stack_full),
    .cnt_zero    (cnt_zero),
    .sel         (sel),
    .push        (push),
    .pop         (pop),
    .cnt_load    (cnt_load),
    .cnt_dec     (cnt_dec),
    .fault       (fault)
  );

  // Loop count comes from the low bits of the data bus
  mac_loop_counter cnt0 (
    .mclk       (mclk),
    .rst_n      (rst_n),
    .load       (cnt_load),
    .dec        (cnt_dec),
    .load_value (cd[CNT_W-1:0]),
    .zero       (cnt_zero)
  );

  // Return address is the call address plus one
  mac_return_stack stk0 (
    .mclk      (mclk),
    .rst_n     (rst_n),
    .push      (push),
    .pop       (pop),
    .push_addr (nlca),
    .top       (pr),
    .empty     (stack_empty),
    .full      (stack_full)
  );

  mac_addr_select asel0 (
    .sel  (sel),
    .lca  (lca),
    .pr   (pr),
    .add  (cmd.add),
    .cd   (cd),
    .nlca (nlca),
    .ica  (ica)
  );

  mac_addr_reg areg0 (
    .mclk    (mclk),
    .rst_n   (rst_n),
    .ica     (ica),
    .eccrhin (eccrhin),
    .lca     (lca),
    .nlca    (nlca),
    .mca     (mca),
    .eccr    (eccr)
  );

endmodule

/* mac_testdata.txt */
# rst op add cd rnd hold eccrhin, then expected lca eccr fault (all hex, one cycle per line)
# op 0 CONT, 1 JUMP, 2 DISP, 3 CALL, 4 RET, 5 LDCNT, 6 LOOP; rnd 1 puts a random word on cd
0 0 0000 0000 0 0 1 0001 1 0
0 1 fffe 0000 1 0 0 fffe 0 0
0 0 0000 0000 0 0 1 ffff 1 0
0 0 0000 0000 0 0 1 0000 1 0
0 2 0000 0120 0 0 0 0120 0 0
0 5 0000 0002 0 0 0 0121 0 0
0 6 0121 0000 1 0 1 0121 1 0
0 6 0121 0000 0 0 0 0121 0 0
0 6 0121 0000 0 0 1 0122 1 0
0 3 0200 0000 0 0 1 0200 1 0
0 3 0300 0000 0 0 0 0300 0 0
0 3 0400 0000 0 1 1 0300 1 0
0 4 0000 0000 0 1 1 0300 1 0
0 3 0400 0000 0 0 0 0400 0 0
0 3 0500 0000 0 0 0 0500 0 0
0 4 0000 0000 1 0 1 0401 1 0
0 4 0000 0000 0 0 0 0301 0 0
0 4 0000 0000 0 0 1 0201 1 0
0 4 0000 0000 0 0 0 0123 0 0
0 4 0000 0000 0 0 1 03f0 1 1
0 1 0100 0000 0 0 1 03f0 1 1
1 0 0000 0000 0 0 1 0000 0 0
0 3 0010 0000 0 0 0 0010 0 0
0 3 0020 0000 0 0 1 0020 1 0
0 3 0030 0000 0 0 0 0030 0 0
0 3 0040 0000 0 0 1 0040 1 0
0 3 0050 0000 0 0 1 03f0 1 1
0 0 0000 0000 0 1 0 03f0 0 1

/* mac_types_pkg.sv */
package mac_types_pkg;
  import mac_cfg_pkg::*;

  // Sequencing commands, one per cycle
  typedef enum logic [2:0] {
    OP_CONT  = 3'd0,
    OP_JUMP  = 3'd1,
    OP_DISP  = 3'd2,
    OP_CALL  = 3'd3,
    OP_RET   = 3'd4,
    OP_LDCNT = 3'd5,
    OP_LOOP  = 3'd6
  } mac_op_t;

  typedef struct packed {
    mac_op_t           op;
    logic [ADDR_W-1:0] add;
  } mac_cmd_t;

  // One strobe per address source
  typedef struct packed {
    logic hold;
    logic psel;
    logic addsel;
    logic cdsel;
    logic nlcasel;
    logic trap;
  } mac_sel_t;

endpackage

/* run_sim.sh */
#!/bin/sh
# Build and run the sequencer testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f vlog.f --top-module tb_mac_sequencer -o sim_mac_sequencer
if [ $? -ne 0 ]; then
  echo "Build failed"
  exit 1
fi

./obj_dir/sim_mac_sequencer > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "^TEST PASS$" sim.log; then
  exit 0
fi
echo "Pass message not found in sim.log"
exit 1

/* tb_mac_sequencer.sv */
`timescale 1ns/1ns

module tb_mac_sequencer
  import mac_cfg_pkg::*;
  import mac_types_pkg::*;
();

  localparam int RESET_CYCLES = 4;

  // One line of the data file
  typedef struct packed {
    logic              rst;
    logic [2:0]        op;
    logic [ADDR_W-1:0] add;
    logic [ADDR_W-1:0] cd;
    logic              rnd;
    logic              hold;
    logic              eccrhin;
    logic [ADDR_W-1:0] lca;
    logic              eccr;
    logic              fault;
  } vec_t;

  logic              mclk;
  logic              rst_n;
  mac_cmd_t          cmd;
  logic [ADDR_W-1:0] cd;
  logic              hold;
  logic              eccrhin;
  logic [ADDR_W-1:0] lca;
  logic [MCA_W-1:0]  mca;
  logic              eccr;
  logic              fault;

  vec_t        vecs [$];
  int          cycles = 0;
  int          limit = 1000000;
  logic [15:0] lfsr_state = 16'd28746;

  // Reference model state
  logic [ADDR_W-1:0]      m_lca;
  logic                   m_eccr;
  logic                   m_fault;
  logic [ADDR_W-1:0]      m_stack [STACK_DEPTH];
  logic [STACK_PTR_W-1:0] m_depth;
  logic [CNT_W-1:0]       m_cnt;

  mac_sequencer dut0 (
    .mclk    (mclk),
    .rst_n   (rst_n),
    .cmd     (cmd),
    .cd      (cd),
    .hold    (hold),
    .eccrhin (eccrhin),
    .lca     (lca),
    .mca     (mca),
    .eccr    (eccr),
    .fault   (fault)
  );

  always #20 mclk = ~mclk;

  always @(posedge mclk) begin
    cycles <= cycles + 1;
    if (cycles > limit) begin
      abort_run("Simulation ran past its cycle limit");
    end
  end

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("TEST FAIL");
    $fatal(1, "Run stopped");
  endtask

  task automatic check_addr(input string name, input logic [ADDR_W-1:0] exp,
                            input logic [ADDR_W-1:0] act);
    if (act !== exp) begin
      abort_run($sformatf("** Error at %0t ns: %s expected %h, got %h", $time, name, exp, act));
    end
  endtask

  task automatic check_mca(input string name, input logic [MCA_W-1:0] exp,
                           input logic [MCA_W-1:0] act);
    if (act !== exp) begin
      abort_run($sformatf("** Error at %0t ns: %s expected %h, got %h", $time, name, exp, act));
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      abort_run($sformatf("** Error at %0t ns: %s expected %b, got %b", $time, name, exp, act));
    end
  endtask

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  task automatic random_word(output logic [ADDR_W-1:0] w);
    w = '0;
    repeat (ADDR_W) begin
      w = {w[ADDR_W-2:0], lfsr_state[15]};
      lfsr_state = lfsr_step(lfsr_state);
    end
  endtask

  task automatic load_vectors();
    int                fd;
    int                n;
    string             line;
    logic [ADDR_W-1:0] f [10];
    vec_t              v;
    fd = $fopen("mac_testdata.txt", "r");
    if (fd == 0) begin
      abort_run("Cannot open mac_testdata.txt");
    end
    while ($fgets(line, fd) != 0) begin
      if (line.len() > 1 && line.getc(0) != "#") begin
        n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h",
                    f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9]);
        if (n != 10) begin
          abort_run($sformatf("Malformed line in mac_testdata.txt: %s", line));
        end
        v.rst     = f[0][0];
        v.op      = f[1][2:0];
        v.add     = f[2];
        v.cd      = f[3];
        v.rnd     = f[4][0];
        v.hold    = f[5][0];
        v.eccrhin = f[6][0];
        v.lca     = f[7];
        v.eccr    = f[8][0];
        v.fault   = f[9][0];
        vecs.push_back(v);
      end
    end
    $fclose(fd);
    if (vecs.size() == 0) begin
      abort_run("No vectors found in mac_testdata.txt");
    end
  endtask

  task automatic model_reset();
    m_lca   = RESET_ADDR;
    m_eccr  = 1'b0;
    m_fault = 1'b0;
    m_depth = '0;
    m_cnt   = '0;
  endtask

  // Steps the sequencing rules by one cycle
  task automatic model_step(input vec_t v, input logic [ADDR_W-1:0] cd_val);
    logic [ADDR_W-1:0] next;
    if (v.rst) begin
      model_reset();
    end else begin
      m_eccr = v.eccrhin;
      // Fault and hold both park on the current address
      if (!m_fault && !v.hold) begin
        next = m_lca + 1'b1;
        case (mac_op_t'(v.op))
          OP_JUMP: next = v.add;
          OP_DISP: next = cd_val;
          OP_CALL: begin
            if (m_depth == STACK_PTR_W'(STACK_DEPTH)) begin
              next    = TRAP_ADDR;
              m_fault = 1'b1;
            end else begin
              m_stack[m_depth[STACK_IDX_W-1:0]] = m_lca + 1'b1;
              m_depth = m_depth + 1'b1;
              next    = v.add;
            end
          end
          OP_RET: begin
            if (m_depth == '0) begin
              next    = TRAP_ADDR;
              m_fault = 1'b1;
            end else begin
              m_depth = m_depth - 1'b1;
              next    = m_stack[m_depth[STACK_IDX_W-1:0]];
            end
          end
          OP_LDCNT: m_cnt = cd_val[CNT_W-1:0];
          OP_LOOP: begin
            if (m_cnt != '0) begin
              next  = v.add;
              m_cnt = m_cnt - 1'b1;
            end
          end
          default: next = m_lca + 1'b1;
        endcase
        m_lca = next;
      end
    end
  endtask

  initial begin
    logic [ADDR_W-1:0] cd_val;
    mclk    = 1'b0;
    rst_n   = 1'b0;
    cmd     = '0;
    cd      = '0;
    hold    = 1'b0;
    eccrhin = 1'b0;
    load_vectors();
    limit = vecs.size() + RESET_CYCLES + 20;
    model_reset();
    repeat (RESET_CYCLES) @(posedge mclk);
    @(negedge mclk);
    foreach (vecs[i]) begin
      cd_val = vecs[i].cd;
      if (vecs[i].rnd) begin
        random_word(cd_val);
      end
      rst_n   = ~vecs[i].rst;
      cmd.op  = mac_op_t'(vecs[i].op);
      cmd.add = vecs[i].add;
      cd      = cd_val;
      hold    = vecs[i].hold;
      eccrhin = vecs[i].eccrhin;
      model_step(vecs[i], cd_val);
      if (m_lca !== vecs[i].lca || m_eccr !== vecs[i].eccr || m_fault !== vecs[i].fault) begin
        abort_run($sformatf("Vector %0d of the data file disagrees with the model", i));
      end
      // Results settle at the rising edge and are read half a cycle later
      @(negedge mclk);
      check_addr("lca", vecs[i].lca, lca);
      check_mca("mca", vecs[i].lca[MCA_W-1:0], mca);
      check_flag("eccr", vecs[i].eccr, eccr);
      check_flag("fault", vecs[i].fault, fault);
    end
    $display("TEST PASS");
    $finish;
  end

endmodule

/* vlog.f */
mac_cfg_pkg.sv
mac_types_pkg.sv
mac_seq_fsm.sv
mac_loop_counter.sv
mac_return_stack.sv
mac_addr_select.sv
mac_addr_reg.sv
mac_sequencer.sv
tb_mac_sequencer.sv
